/* common/perf_settings.svh */
`ifndef PERF_SETTINGS_SVH
`define PERF_SETTINGS_SVH

// width of each event counter, also the wishbone data width
`define PERF_CNT_W 32

// one counter per event class
`define PERF_NUM_CNT 9

// wishbone word address width
`define PERF_ADDR_W 4

`define PERF_XBAR_PORTS 3  // crossbar ports watched for bank conflicts

// counter word addresses
`define PERF_ADR_CYCLES     0
`define PERF_ADR_IMEM       1
`define PERF_ADR_DMEM       2
`define PERF_ADR_RSRV       3
`define PERF_ADR_DX         4
`define PERF_ADR_REDIRECT   5
`define PERF_ADR_CGNI_FULL  6   // processor input buffer full
`define PERF_ADR_CGNO_FULL  7   // processor output buffer full
`define PERF_ADR_CONFLICT   8

`endif

/* common/perf_pkg.sv */
`include "perf_settings.svh"

package perf_pkg;

  // counter slots, value is the wishbone word address
  typedef enum logic [`PERF_ADDR_W-1:0] {
    CNT_CYCLES    = `PERF_ADR_CYCLES,     // non-frozen cycles
    CNT_IMEM      = `PERF_ADR_IMEM,
    CNT_DMEM      = `PERF_ADR_DMEM,
    CNT_RSRV      = `PERF_ADR_RSRV,       // lr.w.acquire wait
    CNT_DX        = `PERF_ADR_DX,         // bypass and load-use
    CNT_REDIRECT  = `PERF_ADR_REDIRECT,   // taken branch penalty
    CNT_CGNI_FULL = `PERF_ADR_CGNI_FULL,
    CNT_CGNO_FULL = `PERF_ADR_CGNO_FULL,
    CNT_CONFLICT  = `PERF_ADR_CONFLICT
  } perf_idx_e;

  // one flag per slot, indexed by perf_idx_e
  typedef logic [`PERF_NUM_CNT-1:0] perf_event_t;

  // counter values, same indexing
  typedef logic [`PERF_NUM_CNT-1:0][`PERF_CNT_W-1:0] perf_cnt_array_t;

endpackage

/* logic/event_sampler.sv */
`include "perf_settings.svh"

module event_sampler
  import perf_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        freeze_i,
  input  logic                        imem_wait_i,
  input  logic                        dmem_wait_i,
  input  logic                        dmem_en_i,
  input  logic                        rsrv_stall_i,
  input  logic                        dx_stall_i,
  input  logic                        redirect_i,
  input  logic                        proc_ready_in_i,
  input  logic                        proc_ready_out_i,
  input  logic [`PERF_XBAR_PORTS-1:0] xbar_v_i,
  input  logic [`PERF_XBAR_PORTS-1:0] xbar_yumi_i,
  output perf_event_t                 event_o,
  output logic                        count_en_o,
  output logic                        clear_o
);

  logic                        freeze_q;
  logic                        freeze_qq;
  logic                        imem_wait_q;
  logic                        dmem_wait_q;
  logic                        dmem_en_q;
  logic                        rsrv_stall_q;
  logic                        dx_stall_q;
  logic                        redirect_q;
  logic                        proc_ready_in_q;
  logic                        proc_ready_out_q;
  logic [`PERF_XBAR_PORTS-1:0] xbar_v_q;
  logic [`PERF_XBAR_PORTS-1:0] xbar_yumi_q;
  logic                        dmem_stall;

  // freeze history starts frozen so a low freeze out of reset is a release
  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      freeze_q  <= 1'b1;
      freeze_qq <= 1'b1;
    end
    else
    begin
      freeze_q  <= freeze_i;
      freeze_qq <= freeze_q;
    end
  end

  always_ff @(posedge clk_i)
  begin
    imem_wait_q      <= imem_wait_i;
    dmem_wait_q      <= dmem_wait_i;
    dmem_en_q        <= dmem_en_i;
    rsrv_stall_q     <= rsrv_stall_i;
    dx_stall_q       <= dx_stall_i;
    redirect_q       <= redirect_i;
    proc_ready_in_q  <= proc_ready_in_i;
    proc_ready_out_q <= proc_ready_out_i;
    xbar_v_q         <= xbar_v_i;
    xbar_yumi_q      <= xbar_yumi_i;
  end

  assign dmem_stall = dmem_wait_q & dmem_en_q;

  always_comb
  begin
    event_o             = '0;
    event_o[CNT_CYCLES] = 1'b1;
    event_o[CNT_IMEM]   = imem_wait_q;
    // one stall class per cycle, highest priority first
    if (dmem_stall)
      event_o[CNT_DMEM] = 1'b1;
    else if (rsrv_stall_q)
      event_o[CNT_RSRV] = 1'b1;
    else if (dx_stall_q)
      event_o[CNT_DX] = 1'b1;
    else if (redirect_q)
      event_o[CNT_REDIRECT] = 1'b1;
    event_o[CNT_CGNI_FULL] = ~proc_ready_out_q;
    event_o[CNT_CGNO_FULL] = ~proc_ready_in_q;
    event_o[CNT_CONFLICT]  = |(xbar_v_q ^ xbar_yumi_q);  // a valid port not served
  end

  assign count_en_o = ~freeze_q;
  assign clear_o    = freeze_qq & ~freeze_q;  // freeze falling edge

endmodule

/* counters/perf_counter_bank.sv */
`include "perf_settings.svh"

module perf_counter_bank
  import perf_pkg::*;
(
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  perf_event_t     event_i,
  input  logic            count_en_i,
  input  logic            clear_i,
  output perf_cnt_array_t cnt_o
);

  perf_event_t inc;

  // events only count in unfrozen cycles
  assign inc = count_en_i ? event_i : '0;

  for (genvar i = 0; i < `PERF_NUM_CNT; i++)
  begin : g_cnt
    localparam perf_idx_e slot_lp = perf_idx_e'(i);

    logic [`PERF_CNT_W-1:0] cnt_q;
    logic [`PERF_CNT_W-1:0] cnt_d;

    // clear wins over a pending increment
    always_comb
    begin
      cnt_d = cnt_q;
      if (clear_i)
        cnt_d = '0;
      else if (inc[slot_lp])
        cnt_d = cnt_q + 1'b1;  // wraps at full scale
    end

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
      if (!arst_n_i)
        cnt_q <= '0;
      else
        cnt_q <= cnt_d;
    end

    assign cnt_o[slot_lp] = cnt_q;
  end

endmodule

/* logic/wb_perf_regs.sv */
`include "perf_settings.svh"

module wb_perf_regs
  import perf_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  logic [`PERF_ADDR_W-1:0] wb_adr_i,
  input  logic [`PERF_CNT_W-1:0]  wb_dat_i,
  input  perf_cnt_array_t         cnt_i,
  output logic [`PERF_CNT_W-1:0]  wb_dat_o,
  output logic                    wb_ack_o
);

  localparam logic [`PERF_ADDR_W-1:0] num_cnt_lp = `PERF_NUM_CNT;

  logic                   req;
  logic                   hit;
  perf_idx_e              sel;
  logic [`PERF_CNT_W-1:0] rd_data;
  logic                   ack_q;
  logic [`PERF_CNT_W-1:0] dat_q;

  // new access only while no ack is out
  assign req = wb_cyc_i & wb_stb_i & ~ack_q;

  assign sel = perf_idx_e'(wb_adr_i);
  assign hit = wb_adr_i < num_cnt_lp;

  always_comb
  begin
    rd_data = '0;
    if (wb_we_i)
      rd_data = wb_dat_i;  // write data loops back, nothing is stored
    else if (hit)
      rd_data = cnt_i[sel];
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      ack_q <= 1'b0;
    else
      ack_q <= req;
  end

  // data captured on the edge that raises ack
  always_ff @(posedge clk_i)
  begin
    if (req)
      dat_q <= rd_data;
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = dat_q;

endmodule

/* logic/tile_perf_monitor.sv */
`include "perf_settings.svh"

module tile_perf_monitor
  import perf_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        freeze_i,
  input  logic                        imem_wait_i,
  input  logic                        dmem_wait_i,
  input  logic                        dmem_en_i,
  input  logic                        rsrv_stall_i,
  input  logic                        dx_stall_i,
  input  logic                        redirect_i,
  input  logic                        proc_ready_in_i,
  input  logic                        proc_ready_out_i,
  input  logic [`PERF_XBAR_PORTS-1:0] xbar_v_i,
  input  logic [`PERF_XBAR_PORTS-1:0] xbar_yumi_i,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  logic [`PERF_ADDR_W-1:0]     wb_adr_i,
  input  logic [`PERF_CNT_W-1:0]      wb_dat_i,
  output logic [`PERF_CNT_W-1:0]      wb_dat_o,
  output logic                        wb_ack_o
);

  perf_event_t     events;
  logic            count_en;
  logic            clear;
  perf_cnt_array_t cnt;

  event_sampler u_event_sampler (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .freeze_i         (freeze_i),
    .imem_wait_i      (imem_wait_i),
    .dmem_wait_i      (dmem_wait_i),
    .dmem_en_i        (dmem_en_i),
    .rsrv_stall_i     (rsrv_stall_i),
    .dx_stall_i       (dx_stall_i),
    .redirect_i       (redirect_i),
    .proc_ready_in_i  (proc_ready_in_i),
    .proc_ready_out_i (proc_ready_out_i),
    .xbar_v_i         (xbar_v_i),
    .xbar_yumi_i      (xbar_yumi_i),
    .event_o          (events),
    .count_en_o       (count_en),
    .clear_o          (clear)
  );

  perf_counter_bank u_perf_counter_bank (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .event_i    (events),
    .count_en_i (count_en),
    .clear_i    (clear),
    .cnt_o      (cnt)
  );

  wb_perf_regs u_wb_perf_regs (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .cnt_i    (cnt),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o)
  );

endmodule

/* testbench/tb_tile_perf_monitor.sv */
`include "perf_settings.svh"

module tb_tile_perf_monitor
  import perf_pkg::*;
();

  localparam int num_tests_lp   = 6;
  localparam int test_cycles_lp = 200;
  localparam int max_cycles_lp  = num_tests_lp * test_cycles_lp + 800;
  localparam int ack_wait_lp    = 4;

  logic                        clk;
  logic                        arst_n;
  logic                        freeze;
  logic                        imem_wait;
  logic                        dmem_wait;
  logic                        dmem_en;
  logic                        rsrv_stall;
  logic                        dx_stall;
  logic                        redirect;
  logic                        proc_ready_in;
  logic                        proc_ready_out;
  logic [`PERF_XBAR_PORTS-1:0] xbar_v;
  logic [`PERF_XBAR_PORTS-1:0] xbar_yumi;
  logic                        wb_cyc;
  logic                        wb_stb;
  logic                        wb_we;
  logic [`PERF_ADDR_W-1:0]     wb_adr;
  logic [`PERF_CNT_W-1:0]      wb_dat_w;
  logic [`PERF_CNT_W-1:0]      wb_dat_r;
  logic                        wb_ack;

  int unsigned            model [`PERF_NUM_CNT];  // expected count per slot
  logic [`PERF_CNT_W-1:0] rd_val [`PERF_NUM_CNT];
  int                     err_cnt;
  int                     tests_passed;
  int                     tests_failed;
  int                     cycle_cnt;

  tile_perf_monitor u_tile_perf_monitor (
    .clk_i            (clk),
    .arst_n_i         (arst_n),
    .freeze_i         (freeze),
    .imem_wait_i      (imem_wait),
    .dmem_wait_i      (dmem_wait),
    .dmem_en_i        (dmem_en),
    .rsrv_stall_i     (rsrv_stall),
    .dx_stall_i       (dx_stall),
    .redirect_i       (redirect),
    .proc_ready_in_i  (proc_ready_in),
    .proc_ready_out_i (proc_ready_out),
    .xbar_v_i         (xbar_v),
    .xbar_yumi_i      (xbar_yumi),
    .wb_cyc_i         (wb_cyc),
    .wb_stb_i         (wb_stb),
    .wb_we_i          (wb_we),
    .wb_adr_i         (wb_adr),
    .wb_dat_i         (wb_dat_w),
    .wb_dat_o         (wb_dat_r),
    .wb_ack_o         (wb_ack)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // inputs change 1 unit after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic drive_idle();
    imem_wait      = 1'b0;
    dmem_wait      = 1'b0;
    dmem_en        = 1'b0;
    rsrv_stall     = 1'b0;
    dx_stall       = 1'b0;
    redirect       = 1'b0;
    proc_ready_in  = 1'b1;
    proc_ready_out = 1'b1;
    xbar_v         = '0;
    xbar_yumi      = '0;
  endtask

  task automatic drive_random();
    imem_wait      = 1'($urandom);
    dmem_wait      = 1'($urandom);
    dmem_en        = 1'($urandom);
    rsrv_stall     = 1'($urandom);
    dx_stall       = 1'($urandom);
    redirect       = 1'($urandom);
    proc_ready_in  = 1'($urandom);
    proc_ready_out = 1'($urandom);
    xbar_v         = `PERF_XBAR_PORTS'($urandom);
    xbar_yumi      = `PERF_XBAR_PORTS'($urandom);
  endtask

  // one unfrozen cycle of the current status
  task automatic count_cycle();
    model[CNT_CYCLES]++;
    if (imem_wait)
      model[CNT_IMEM]++;
    if (dmem_wait && dmem_en)
      model[CNT_DMEM]++;
    else if (rsrv_stall)
      model[CNT_RSRV]++;
    else if (dx_stall)
      model[CNT_DX]++;
    else if (redirect)
      model[CNT_REDIRECT]++;
    if (!proc_ready_out)
      model[CNT_CGNI_FULL]++;
    if (!proc_ready_in)
      model[CNT_CGNO_FULL]++;
    if (xbar_v != xbar_yumi)
      model[CNT_CONFLICT]++;
    next_cycle();
  endtask

  task automatic release_freeze();
    drive_idle();
    freeze = 1'b0;
    next_cycle();  // sample used up by the clear
    foreach (model[i])
      model[i] = 0;
  endtask

  task automatic hold_freeze();
    drive_idle();
    freeze = 1'b1;
    next_cycle();  // last unfrozen sample counts on this edge
  endtask

  task automatic bus_access(input logic we, input logic [`PERF_ADDR_W-1:0] adr,
                            input logic [`PERF_CNT_W-1:0] wdata,
                            output logic [`PERF_CNT_W-1:0] rdata);
    int waited;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    next_cycle();
    waited = 1;
    while (!wb_ack && waited < ack_wait_lp)
    begin
      next_cycle();
      waited++;
    end
    if (!wb_ack)
    begin
      $display("no ack from the slave within %0d cycles at address %0d", ack_wait_lp, adr);
      err_cnt++;
      rdata = '0;
    end
    else
      rdata = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    next_cycle();
  endtask

  task automatic check_value(input string name, input logic [`PERF_CNT_W-1:0] exp,
                             input logic [`PERF_CNT_W-1:0] got);
    assert (got == exp)
    else
    begin
      $display("Fail %s expected %h got %h", name, exp, got);
      err_cnt++;
    end
  endtask

  task automatic check_counters();
    logic [`PERF_CNT_W-1:0] rd;
    perf_idx_e              idx;
    for (int i = 0; i < `PERF_NUM_CNT; i++)
    begin
      idx = perf_idx_e'(i);
      bus_access(1'b0, idx, '0, rd);
      rd_val[i] = rd;
      check_value(idx.name(), model[i], rd);
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    if (err_cnt == err_before)
    begin
      tests_passed++;
      $display("test %s ok", name);
    end
    else
    begin
      tests_failed++;
      $display("test %s failed with %0d errors", name, err_cnt - err_before);
    end
  endtask

  initial
  begin
    int                     err_before;
    int                     n;
    logic [`PERF_CNT_W-1:0] rd;
    void'($urandom(32'he3f99c67));
    arst_n   = 1'b0;
    freeze   = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    drive_idle();
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;

    err_before = err_cnt;
    check_counters();
    bus_access(1'b0, 4'd12, '0, rd);
    check_value("wb_dat_o", '0, rd);  // unmapped address
    release_freeze();
    hold_freeze();
    check_counters();
    bus_access(1'b1, CNT_CYCLES, 32'hdead_beef, rd);
    bus_access(1'b0, CNT_CYCLES, '0, rd);
    check_value("CNT_CYCLES", '0, rd);
    finish_test("reset and clear", err_before);

    err_before = err_cnt;
    n = $urandom_range(60, 20);
    release_freeze();
    repeat (n) count_cycle();
    hold_freeze();
    check_counters();
    // a write must leave a nonzero count alone
    bus_access(1'b1, CNT_CYCLES, 32'hdead_beef, rd);
    bus_access(1'b0, CNT_CYCLES, '0, rd);
    check_value("CNT_CYCLES", n, rd);
    finish_test("idle cycles", err_before);

    err_before = err_cnt;
    n = $urandom_range(120, 60);
    release_freeze();
    repeat (n)
    begin
      drive_idle();
      dmem_wait  = 1'($urandom);
      dmem_en    = 1'($urandom);
      rsrv_stall = 1'($urandom);
      dx_stall   = 1'($urandom);
      redirect   = 1'($urandom);
      count_cycle();
    end
    hold_freeze();
    check_counters();
    assert (rd_val[CNT_DMEM] + rd_val[CNT_RSRV] + rd_val[CNT_DX] + rd_val[CNT_REDIRECT]
            <= rd_val[CNT_CYCLES])
    else
    begin
      $display("stall counts add up to more than the cycle count");
      err_cnt++;
    end
    // unmapped addresses while the low slots hold counts
    for (int a = `PERF_NUM_CNT; a < (1 << `PERF_ADDR_W); a++)
    begin
      bus_access(1'b0, a[`PERF_ADDR_W-1:0], '0, rd);
      check_value("wb_dat_o", '0, rd);
    end
    finish_test("stall priority", err_before);

    err_before = err_cnt;
    n = $urandom_range(120, 60);
    release_freeze();
    repeat (n)
    begin
      drive_idle();
      imem_wait      = 1'($urandom);
      proc_ready_in  = 1'($urandom);
      proc_ready_out = 1'($urandom);
      count_cycle();
    end
    hold_freeze();
    check_counters();
    finish_test("imem and buffers", err_before);

    err_before = err_cnt;
    n = $urandom_range(120, 60);
    release_freeze();
    repeat (n)
    begin
      drive_idle();
      xbar_v    = `PERF_XBAR_PORTS'($urandom);
      xbar_yumi = `PERF_XBAR_PORTS'($urandom);
      count_cycle();
    end
    hold_freeze();
    check_counters();
    finish_test("bank conflicts", err_before);

    // counts from the last test must survive a frozen stretch
    err_before = err_cnt;
    repeat (40)
    begin
      drive_random();
      next_cycle();
    end
    drive_idle();
    check_counters();
    release_freeze();
    hold_freeze();
    check_counters();
    finish_test("freeze hold", err_before);

    $display("tests passed %0d failed %0d errors %0d", tests_passed, tests_failed, err_cnt);
    if (tests_failed == 0 && err_cnt == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < max_cycles_lp)
    begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("run stopped after %0d cycles without finishing", max_cycles_lp);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+common
common/perf_pkg.sv
logic/event_sampler.sv
counters/perf_counter_bank.sv
logic/wb_perf_regs.sv
logic/tile_perf_monitor.sv
testbench/tb_tile_perf_monitor.sv

/* Makefile */
# Verilator build and run of the tile performance monitor testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_tile_perf_monitor \
		-f verilog.f -o sim
	./obj_dir/sim > sim.log 2>&1; cat sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
